// ==== filelist.f ====
hw/self_output_pkg.sv
hw/stream_if.sv
hw/self_output_ctrl.sv
hw/requant_stage.sv
hw/residual_add.sv
hw/self_output_top.sv
tests/self_output_props.sv
tests/tb_self_output.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the self output testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_self_output \
  -f filelist.f \
  -o sim_self_output

./obj_dir/sim_self_output

// ==== tests/tb_self_output.sv ====
// Self output core testbench
`timescale 1ns/10ps
`default_nettype none

module tb_self_output;

  localparam int TOKENS  = 4;
  localparam int EMBED   = 8;
  localparam int RUN_LEN = TOKENS * EMBED;
  // Five runs, four cycles per element at most, plus reset and drain
  localparam int TIMEOUT_CYCLES = 5 * RUN_LEN * 4 + 200;

  logic clk;
  logic rstn;
  logic start;
  logic acc_valid;
  logic res_valid;
  logic out_ready;
  self_output_pkg::mult_t  m_mm;
  self_output_pkg::shift_t e_mm;
  self_output_pkg::mult_t  m_out;
  self_output_pkg::shift_t e_out;
  self_output_pkg::acc_t   acc_data;
  self_output_pkg::byte_t  res_data;
  logic busy;
  logic done;
  logic acc_ready;
  logic res_ready;
  logic out_valid;
  logic out_last;
  self_output_pkg::byte_t  out_data;

  // Reference copy of the requant settings
  self_output_pkg::mult_t  cfg_m_mm;
  self_output_pkg::shift_t cfg_e_mm;
  self_output_pkg::mult_t  cfg_m_out;
  self_output_pkg::shift_t cfg_e_out;

  // Stimulus and expected output of one run
  self_output_pkg::acc_t  acc_q[$];
  self_output_pkg::byte_t res_q[$];
  self_output_pkg::byte_t exp_q[$];

  logic [31:0] rng = 32'hfbec;
  int cycle_cnt = 0;
  int done_cnt = 0;

  self_output_top #(.TOKENS(TOKENS), .EMBED(EMBED)) dut (
    .clk (clk), .rstn (rstn), .start (start),
    .requant_m_mm (m_mm), .requant_e_mm (e_mm),
    .requant_m_out (m_out), .requant_e_out (e_out),
    .acc_valid (acc_valid), .acc_data (acc_data),
    .res_valid (res_valid), .res_data (res_data), .out_ready (out_ready),
    .busy (busy), .done (done), .acc_ready (acc_ready), .res_ready (res_ready),
    .out_valid (out_valid), .out_data (out_data), .out_last (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // Timeout and done counting
  // ==========================================================

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  always @(posedge clk) begin
    if (done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  // ==========================================================
  // Reference model and helpers
  // ==========================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Multiply, round half up, arithmetic shift right
  function automatic longint requant_ref(input longint x, input longint m, input int e);
    longint p;
    p = x * m;
    if (e > 0) begin
      p = p + (longint'(1) <<< (e - 1));
    end
    return p >>> e;
  endfunction

  function automatic self_output_pkg::byte_t expected_out(
    input self_output_pkg::acc_t a, input self_output_pkg::byte_t r);
    longint scaled;
    longint sum;
    longint y;
    // First stage keeps the low 32 bits
    scaled = longint'(int'(requant_ref(a, cfg_m_mm, cfg_e_mm)));
    sum = scaled + r;
    if (sum > 2097151) sum = 2097151;
    if (sum < -2097152) sum = -2097152;
    y = requant_ref(sum, cfg_m_out, cfg_e_out);
    if (y > 127) y = 127;
    if (y < -128) y = -128;
    return self_output_pkg::byte_t'(y);
  endfunction

  task automatic check_eq(input string what, input logic signed [63:0] got,
                          input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic set_config(input self_output_pkg::mult_t m1, input self_output_pkg::shift_t e1,
                            input self_output_pkg::mult_t m2, input self_output_pkg::shift_t e2);
    cfg_m_mm  = m1;
    cfg_e_mm  = e1;
    cfg_m_out = m2;
    cfg_e_out = e2;
    @(posedge clk);
    m_mm  <= m1;
    e_mm  <= e1;
    m_out <= m2;
    e_out <= e2;
  endtask

  task automatic random_config();
    logic [31:0] r1;
    logic [31:0] r2;
    rng = xorshift32(rng);
    r1  = rng;
    rng = xorshift32(rng);
    r2  = rng;
    set_config($signed(r1[15:0]), 8'd4 + r1[19:16], $signed(r2[11:0]), 8'd8 + r2[14:12]);
  endtask

  // Accumulators drawn at the given signed width
  task automatic fill_run(input int acc_w);
    self_output_pkg::acc_t  a;
    self_output_pkg::byte_t r;
    acc_q.delete();
    res_q.delete();
    exp_q.delete();
    for (int i = 0; i < RUN_LEN; i++) begin
      rng = xorshift32(rng);
      a = rng;
      // Sign extend from the top bit of the chosen width
      a = (a <<< (32 - acc_w)) >>> (32 - acc_w);
      rng = xorshift32(rng);
      r = rng[7:0];
      acc_q.push_back(a);
      res_q.push_back(r);
      exp_q.push_back(expected_out(a, r));
    end
  endtask

  // ==========================================================
  // One run with feeders and output checker
  // ==========================================================

  task automatic run_once(input bit bp, input bit extra_start);
    int acc_idx;
    int res_idx;
    int out_idx;
    int done_before;
    logic [31:0] rv_rng;
    logic [31:0] or_rng;
    acc_idx = 0;
    res_idx = 0;
    out_idx = 0;
    done_before = done_cnt;
    rv_rng = rng ^ 32'h5a5a1234;
    or_rng = rng ^ 32'h0f0f8765;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    fork
      begin
        acc_valid <= 1'b1;
        acc_data  <= acc_q[0];
        while (acc_idx < RUN_LEN) begin
          @(posedge clk);
          if (acc_ready) begin
            acc_idx++;
            if (acc_idx < RUN_LEN) acc_data <= acc_q[acc_idx];
            else acc_valid <= 1'b0;
          end
        end
      end
      begin
        while (res_idx < RUN_LEN) begin
          @(posedge clk);
          if (res_valid && res_ready) res_idx++;
          if (res_idx >= RUN_LEN) begin
            res_valid <= 1'b0;
          end else if (!res_valid || res_ready) begin
            rv_rng = xorshift32(rv_rng);
            // Valid three times in four under back-pressure
            res_valid <= !bp || (rv_rng[1:0] != 2'd0);
            res_data  <= res_q[res_idx];
          end
        end
      end
      begin
        while (out_idx < RUN_LEN) begin
          @(posedge clk);
          if (out_valid && out_ready) begin
            check_eq("out_data", out_data, exp_q[out_idx]);
            check_eq("out_last", out_last, out_idx == RUN_LEN - 1);
            out_idx++;
          end
          or_rng = xorshift32(or_rng);
          out_ready <= !bp || (or_rng[1:0] != 2'd0) || (out_idx >= RUN_LEN);
        end
        // Done and busy change on the edge of the last transfer
        @(negedge clk);
        check_eq("done after last beat", done, 1);
        check_eq("busy after last beat", busy, 0);
        @(negedge clk);
        check_eq("done one cycle later", done, 0);
        check_eq("out_valid after run", out_valid, 0);
        check_eq("done pulse count", done_cnt, done_before + 1);
      end
      begin
        if (extra_start) begin
          repeat (6) @(posedge clk);
          check_eq("busy at second start", busy, 1);
          start <= 1'b1;
          @(posedge clk);
          start <= 1'b0;
        end
      end
    join
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================

  task automatic idle_after_reset();
    @(negedge clk);
    check_eq("busy after reset", busy, 0);
    check_eq("done after reset", done, 0);
    check_eq("out_valid after reset", out_valid, 0);
    check_eq("acc_ready after reset", acc_ready, 0);
    check_eq("res_ready after reset", res_ready, 0);
    @(posedge clk);
    acc_valid <= 1'b1;
    acc_data  <= 32'sd1234;
    repeat (5) begin
      @(negedge clk);
      check_eq("acc_ready without start", acc_ready, 0);
      check_eq("out_valid without start", out_valid, 0);
    end
    @(posedge clk);
    acc_valid <= 1'b0;
  endtask

  // Byte sized accumulators, so sums land in and out of the byte range
  task automatic identity_run();
    set_config(32'sd1, 8'd0, 32'sd1, 8'd0);
    fill_run(8);
    run_once(1'b0, 1'b0);
  endtask

  task automatic full_range_run();
    random_config();
    fill_run(32);
    run_once(1'b0, 1'b0);
  endtask

  task automatic backpressure_run();
    random_config();
    fill_run(24);
    run_once(1'b1, 1'b0);
  endtask

  // Start during a run, then a second clean run
  task automatic sequencing_runs();
    random_config();
    fill_run(24);
    run_once(1'b0, 1'b1);
    fill_run(32);
    run_once(1'b0, 1'b0);
  endtask

  initial begin
    rstn      = 1'b0;
    start     = 1'b0;
    m_mm      = 32'sd1;
    e_mm      = 8'd0;
    m_out     = 32'sd1;
    e_out     = 8'd0;
    acc_valid = 1'b0;
    acc_data  = '0;
    res_valid = 1'b0;
    res_data  = '0;
    out_ready = 1'b1;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    idle_after_reset();
    identity_run();
    full_range_run();
    backpressure_run();
    sequencing_runs();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/self_output_props.sv ====
// Stream and control assertions
`timescale 1ns/10ps
`default_nettype none

module self_output_props (
  input logic                   clk,
  input logic                   rstn,
  input logic                   busy,
  input logic                   done,
  input logic                   acc_ready,
  input logic                   res_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic                   out_last,
  input self_output_pkg::byte_t out_data
);

  // ==========================================================
  // Output stream and run control
  // ==========================================================

  // Stalled beat stays put
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("Output beat changed while stalled");

  // Single cycle strobe
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    done |=> !done)
    else $error("done held high for more than one cycle");

  // No admission outside a run, pipeline drained while idle
  a_idle_gate: assert property (@(posedge clk) disable iff (!rstn)
    !busy |-> !acc_ready && !res_ready && !out_valid)
    else $error("Handshake active while idle");

endmodule

bind self_output_top self_output_props props (
  .clk       (clk),
  .rstn      (rstn),
  .busy      (busy),
  .done      (done),
  .acc_ready (acc_ready),
  .res_ready (res_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last),
  .out_data  (out_data)
);

`default_nettype wire

// ==== hw/self_output_top.sv ====
// Self output compute core
`timescale 1ns/10ps
`default_nettype none

module self_output_top #(
  parameter int TOKENS = 4,
  parameter int EMBED  = 8
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start,
  input  self_output_pkg::mult_t  requant_m_mm,
  input  self_output_pkg::shift_t requant_e_mm,
  input  self_output_pkg::mult_t  requant_m_out,
  input  self_output_pkg::shift_t requant_e_out,
  input  logic                    acc_valid,
  input  self_output_pkg::acc_t   acc_data,
  input  logic                    res_valid,
  input  self_output_pkg::byte_t  res_data,
  input  logic                    out_ready,
  output logic                    busy,
  output logic                    done,
  output logic                    acc_ready,
  output logic                    res_ready,
  output logic                    out_valid,
  output self_output_pkg::byte_t  out_data,
  output logic                    out_last
);

  // ==========================================================
  // Pipeline streams
  // ==========================================================

  stream_if #(.payload_t(self_output_pkg::acc_t))  acc_s ();
  stream_if #(.payload_t(self_output_pkg::acc_t))  scaled_s ();
  stream_if #(.payload_t(self_output_pkg::sum_t))  sum_s ();
  stream_if #(.payload_t(self_output_pkg::byte_t)) out_s ();

  // Run sequencing and admission
  self_output_ctrl #(
    .TOKENS (TOKENS),
    .EMBED  (EMBED)
  ) ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .acc_valid (acc_valid),
    .acc_data  (acc_data),
    .acc_ready (acc_ready),
    .acc_s     (acc_s.src),
    .out_s     (out_s.mon)
  );

  // Matmul requant, 32 bits kept without clipping
  requant_stage #(
    .in_t  (self_output_pkg::acc_t),
    .out_t (self_output_pkg::acc_t),
    .CLIP  (1'b0)
  ) requant_mm (
    .clk   (clk),
    .rstn  (rstn),
    .mult  (requant_m_mm),
    .shift (requant_e_mm),
    .in_s  (acc_s.snk),
    .out_s (scaled_s.src)
  );

  // Residual join, 22 bit saturated sum
  residual_add res_add (
    .clk       (clk),
    .rstn      (rstn),
    .y_s       (scaled_s.snk),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready),
    .z_s       (sum_s.src)
  );

  // Output requant, clipped to a byte
  requant_stage #(
    .in_t  (self_output_pkg::sum_t),
    .out_t (self_output_pkg::byte_t),
    .CLIP  (1'b1)
  ) requant_out (
    .clk   (clk),
    .rstn  (rstn),
    .mult  (requant_m_out),
    .shift (requant_e_out),
    .in_s  (sum_s.snk),
    .out_s (out_s.src)
  );

  // Output stream onto plain ports
  assign out_valid   = out_s.valid;
  assign out_data    = out_s.data;
  assign out_last    = out_s.last;
  assign out_s.ready = out_ready;

endmodule

`default_nettype wire

// ==== hw/residual_add.sv ====
// Residual join and saturating add
`timescale 1ns/10ps
`default_nettype none

module residual_add (
  input  logic                   clk,
  input  logic                   rstn,
  stream_if.snk                  y_s,
  input  logic                   res_valid,
  input  self_output_pkg::byte_t res_data,
  output logic                   res_ready,
  stream_if.src                  z_s
);

  // One guard bit over the accumulator
  localparam int WIDE_W = self_output_pkg::D_W_ACC + 1;
  localparam int LN_W   = self_output_pkg::LN_BITS;
  localparam logic signed [WIDE_W-1:0] SUM_MAX = WIDE_W'((1 <<< (LN_W - 1)) - 1);
  localparam logic signed [WIDE_W-1:0] SUM_MIN = WIDE_W'(-(1 <<< (LN_W - 1)));

  logic                  can_take;
  logic                  fire;
  logic signed [WIDE_W-1:0] wide_sum;
  self_output_pkg::sum_t sat_sum;

  logic                  z_valid;
  logic                  z_last;
  self_output_pkg::sum_t z_data;

  // ==========================================================
  // Join
  // ==========================================================

  // Output register free or emptying now
  assign can_take  = ~z_valid | z_s.ready;
  // Each side is ready only when the other side has a beat
  assign y_s.ready = res_valid & can_take;
  assign res_ready = y_s.valid & can_take;
  assign fire      = y_s.valid & res_valid & can_take;

  // ==========================================================
  // Add and saturate
  // ==========================================================

  // Residual sign extends directly
  assign wide_sum = WIDE_W'(y_s.data) + WIDE_W'(res_data);

  assign sat_sum = (wide_sum > SUM_MAX) ? self_output_pkg::sum_t'(SUM_MAX) :
                   (wide_sum < SUM_MIN) ? self_output_pkg::sum_t'(SUM_MIN) :
                   self_output_pkg::sum_t'(wide_sum);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      z_valid <= 1'b0;
    end else if (can_take) begin
      z_valid <= fire;
    end
  end

  // Last rides with the accumulator side
  always_ff @(posedge clk) begin
    if (fire) begin
      z_data <= sat_sum;
      z_last <= y_s.last;
    end
  end

  assign z_s.valid = z_valid;
  assign z_s.data  = z_data;
  assign z_s.last  = z_last;

endmodule

`default_nettype wire

// ==== hw/requant_stage.sv ====
// Registered requantization stage
`timescale 1ns/10ps
`default_nettype none

module requant_stage #(
  parameter type in_t  = self_output_pkg::acc_t,
  parameter type out_t = self_output_pkg::acc_t,
  parameter bit  CLIP  = 1'b0
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  self_output_pkg::mult_t  mult,
  input  self_output_pkg::shift_t shift,
  stream_if.snk                   in_s,
  stream_if.src                   out_s
);

  // Signed range of the output type
  localparam int OUT_W = $bits(out_t);
  localparam logic signed [63:0] OUT_MAX = (64'sd1 <<< (OUT_W - 1)) - 64'sd1;
  localparam logic signed [63:0] OUT_MIN = -(64'sd1 <<< (OUT_W - 1));

  // Input beat at its own payload type
  in_t                in_data;
  logic signed [63:0] prod;
  logic signed [63:0] rnd;
  logic signed [63:0] shifted;
  out_t               result;

  // Output register
  logic out_valid;
  logic out_last;
  out_t out_data;

  // ==========================================================
  // Arithmetic
  // ==========================================================

  assign in_data = in_s.data;

  // Full product fits in 64 bits for inputs up to 32 bits
  assign prod = 64'(in_data) * 64'(mult);

  // Half an output unit, round to nearest
  assign rnd = (shift != '0) ? (64'sd1 <<< (shift - 8'd1)) : 64'sd0;

  assign shifted = (prod + rnd) >>> shift;

  always_comb begin
    if (CLIP) begin
      if (shifted > OUT_MAX) begin
        result = out_t'(OUT_MAX);
      end else if (shifted < OUT_MIN) begin
        result = out_t'(OUT_MIN);
      end else begin
        result = out_t'(shifted);
      end
    end else begin
      // Plain truncation to the output width
      result = out_t'(shifted);
    end
  end

  // ==========================================================
  // Single output register
  // ==========================================================

  // Accept when empty or draining this cycle
  assign in_s.ready = ~out_valid | out_s.ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else if (in_s.ready) begin
      out_valid <= in_s.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_s.valid && in_s.ready) begin
      out_data <= result;
      out_last <= in_s.last;
    end
  end

  assign out_s.valid = out_valid;
  assign out_s.data  = out_data;
  assign out_s.last  = out_last;

endmodule

`default_nettype wire

// ==== hw/self_output_ctrl.sv ====
// Self output run control
`timescale 1ns/10ps
`default_nettype none

module self_output_ctrl #(
  parameter int TOKENS = 4,
  parameter int EMBED  = 8
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  input  logic                  acc_valid,
  input  self_output_pkg::acc_t acc_data,
  output logic                  acc_ready,
  stream_if.src                 acc_s,
  stream_if.mon                 out_s
);

  // Elements in one run
  localparam int RUN_LEN = TOKENS * EMBED;
  localparam int CNT_W   = (RUN_LEN > 1) ? $clog2(RUN_LEN) : 1;
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(RUN_LEN - 1);

  // Index of the next beat to admit
  logic [CNT_W-1:0] beat_cnt;
  logic             admit;
  logic             last_out;

  // ==========================================================
  // Accumulator admission
  // ==========================================================

  // Nothing enters the pipeline outside a run
  assign acc_s.valid = busy & acc_valid;
  assign acc_s.data  = acc_data;
  // Final element of the run
  assign acc_s.last  = (beat_cnt == LAST_IDX);
  assign acc_ready   = busy & acc_s.ready;

  assign admit = acc_s.valid & acc_s.ready;

  // Last output beat leaving the core
  assign last_out = out_s.valid & out_s.ready & out_s.last;

  // ==========================================================
  // Run state
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      beat_cnt <= '0;
    end else begin
      // One cycle strobe, busy drops on the same edge
      done <= busy & last_out;
      if (!busy) begin
        if (start) begin
          busy     <= 1'b1;
          beat_cnt <= '0;
        end
      end else begin
        if (admit) begin
          // Wraps so the next run starts at index 0
          beat_cnt <= (beat_cnt == LAST_IDX) ? '0 : beat_cnt + 1'b1;
        end
        if (last_out) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/stream_if.sv ====
// Valid ready stream
`timescale 1ns/10ps
`default_nettype none

interface stream_if #(
  parameter type payload_t = logic
) ();

  // Handshake
  logic valid;
  logic ready;

  // Beat contents, held stable until the beat transfers
  logic last;
  payload_t data;

  // Producer side
  modport src (output valid, output last, output data, input ready);

  // Consumer side
  modport snk (input valid, input last, input data, output ready);

  // Observer only
  modport mon (input valid, input ready, input last, input data);

endinterface

`default_nettype wire

// ==== hw/self_output_pkg.sv ====
// Self output shared types
`default_nettype none

package self_output_pkg;

  // ==========================================================
  // Element widths
  // ==========================================================

  // Residual and output element
  parameter int D_W = 8;
  // Matmul accumulator
  parameter int D_W_ACC = 32;
  // Saturated residual sum, toward the normalization input
  parameter int LN_BITS = 22;

  // ==========================================================
  // Payload types
  // ==========================================================

  // Residual byte and final output byte
  typedef logic signed [D_W-1:0] byte_t;

  // Accumulator, also the first requant result
  typedef logic signed [D_W_ACC-1:0] acc_t;

  // Residual sum after saturation
  typedef logic signed [LN_BITS-1:0] sum_t;

  // ==========================================================
  // Requant fields
  // ==========================================================

  // Fixed point multiplier
  typedef logic signed [31:0] mult_t;

  // Right shift amount, 0 to 31 in use
  typedef logic [7:0] shift_t;

endpackage

`default_nettype wire
